// File: source/fetch_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module fetch_buffer
  import mem_pkg::*;
  import fetch_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         flush,
  input  logic         req_valid,
  input  line_addr_t   req_addr,
  input  logic         rsp_valid,
  input  mem_rsp_t     rsp,
  input  epoch_t       epoch,
  input  logic         pop,
  output fetch_entry_t head,
  output logic         empty,
  output logic         full
);

  localparam int PTR_W   = `FETCH_PTR_W;
  localparam int STALE_W = `FETCH_PTR_W + 4;

  typedef logic [PTR_W:0] ptr_t;   // msb is the wrap bit.

  fetch_entry_t       line_q [`FETCH_DEPTH];
  line_addr_t         addr_q [`FETCH_DEPTH];
  ptr_t               wptr;
  ptr_t               rptr;
  ptr_t               aq_wptr;
  ptr_t               aq_rptr;
  ptr_t               aq_count;
  logic [STALE_W-1:0] stale_cnt;
  logic               rsp_stale;
  logic               rsp_take;

  // requests of the current epoch still waiting for their line.
  assign aq_count = aq_wptr - aq_rptr;

  // two quick redirects bring the epoch bit back to an old value,
  // so responses left over from before a flush are also counted out.
  assign rsp_stale = (stale_cnt != '0) || (rsp.epoch != epoch);
  assign rsp_take  = rsp_valid && !rsp_stale;

  assign empty = (rptr == wptr);
  assign full  = (rptr == {~wptr[PTR_W], wptr[PTR_W-1:0]});
  assign head  = line_q[rptr[PTR_W-1:0]];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wptr      <= '0;
      rptr      <= '0;
      aq_wptr   <= '0;
      aq_rptr   <= '0;
      stale_cnt <= '0;
    end else if (flush) begin
      wptr      <= '0;
      rptr      <= '0;
      aq_wptr   <= '0;
      aq_rptr   <= '0;
      // everything still in flight now belongs to an old epoch.
      stale_cnt <= stale_cnt + STALE_W'(aq_count) + STALE_W'(req_valid)
                   - STALE_W'(rsp_valid);
    end else begin
      if (req_valid) begin
        aq_wptr <= aq_wptr + 1'b1;
      end
      if (rsp_take) begin
        aq_rptr <= aq_rptr + 1'b1;
        wptr    <= wptr + 1'b1;
      end
      if (pop && !empty) begin
        rptr <= rptr + 1'b1;
      end
      if (rsp_valid && stale_cnt != '0) begin
        stale_cnt <= stale_cnt - 1'b1;   // dropped without a trace.
      end
    end
  end

  // storage, no reset.
  always_ff @(posedge clk) begin
    if (req_valid) begin
      addr_q[aq_wptr[PTR_W-1:0]] <= req_addr;
    end
    if (rsp_take) begin
      line_q[wptr[PTR_W-1:0]].addr <= addr_q[aq_rptr[PTR_W-1:0]];
      line_q[wptr[PTR_W-1:0]].data <= rsp.data;
    end
  end

endmodule

`default_nettype wire

// File: source/fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// fetch buffer depth in lines, must be a power of two.
`define FETCH_DEPTH 4
`define FETCH_PTR_W 2

// one memory line holds four 32-bit instructions.
`define LINE_BYTES 16
`define WORDS_PER_LINE 4

`define ADDR_W 32

// first fetch address after reset.
`define RESET_PC 32'h8000_0000

`endif

// File: source/fetch_pc_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module fetch_pc_gen
  import mem_pkg::*;
  import fetch_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     redirect_valid,
  input  pc_t      redirect_pc,
  input  logic     pop,
  output logic     mem_req_valid,
  output mem_req_t mem_req,
  output epoch_t   epoch
);

  localparam int CREDIT_W = `FETCH_PTR_W + 1;

  line_addr_t          next_addr;
  line_addr_t          redirect_line;
  logic [CREDIT_W-1:0] credits;
  logic                can_issue;

  assign redirect_line = line_addr_t'(redirect_pc & ~pc_t'(`LINE_BYTES - 1));

  // a free credit means a free buffer slot for the response.
  assign can_issue = (credits != '0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      next_addr     <= `RESET_PC;
      credits       <= CREDIT_W'(`FETCH_DEPTH);
      epoch         <= 1'b0;
      mem_req_valid <= 1'b0;
    end else if (redirect_valid) begin
      // restart at the target line, all older lines are dropped.
      next_addr     <= redirect_line + line_addr_t'(`LINE_BYTES);
      credits       <= CREDIT_W'(`FETCH_DEPTH - 1);
      epoch         <= ~epoch;
      mem_req_valid <= 1'b1;
    end else begin
      mem_req_valid <= can_issue;
      if (can_issue) begin
        next_addr <= next_addr + line_addr_t'(`LINE_BYTES);
      end
      credits <= credits + CREDIT_W'(pop) - CREDIT_W'(can_issue);
    end
  end

  // request payload.
  always_ff @(posedge clk) begin
    if (redirect_valid) begin
      mem_req.addr  <= redirect_line;
      mem_req.epoch <= ~epoch;   // the epoch that starts at this edge.
    end else if (can_issue) begin
      mem_req.addr  <= next_addr;
      mem_req.epoch <= epoch;
    end
  end

endmodule

`default_nettype wire

// File: source/fetch_pkg.sv
`default_nettype none

`include "fetch_params.svh"

package fetch_pkg;

  import mem_pkg::*;

  typedef logic [`ADDR_W-1:0] pc_t;

  typedef logic [31:0] inst_t;

  // index of a word within a line.
  typedef logic [$clog2(`WORDS_PER_LINE)-1:0] word_off_t;

  // one buffered line with the address it was fetched from.
  typedef struct packed {
    line_addr_t addr;
    line_data_t data;
  } fetch_entry_t;

  // what the decoder sees.
  typedef struct packed {
    pc_t   pc;
    inst_t inst;
  } fetch_inst_t;

endpackage

`default_nettype wire

// File: source/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module fetch_top
  import mem_pkg::*;
  import fetch_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        redirect_valid,
  input  pc_t         redirect_pc,
  input  logic        mem_rsp_valid,
  input  mem_rsp_t    mem_rsp,
  input  logic        inst_ready,
  output logic        mem_req_valid,
  output mem_req_t    mem_req,
  output logic        inst_valid,
  output fetch_inst_t inst_out
);

  epoch_t       epoch;
  fetch_entry_t head;
  logic         empty;
  logic         full;   // watched by the bound checker.
  logic         pop;

  fetch_pc_gen u_pc_gen (
    .clk            (clk),
    .rst_n          (rst_n),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .pop            (pop),
    .mem_req_valid  (mem_req_valid),
    .mem_req        (mem_req),
    .epoch          (epoch)
  );

  // the request strobe also feeds the buffer's address queue.
  fetch_buffer u_buffer (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush     (redirect_valid),
    .req_valid (mem_req_valid),
    .req_addr  (mem_req.addr),
    .rsp_valid (mem_rsp_valid),
    .rsp       (mem_rsp),
    .epoch     (epoch),
    .pop       (pop),
    .head      (head),
    .empty     (empty),
    .full      (full)
  );

  inst_aligner u_aligner (
    .clk            (clk),
    .rst_n          (rst_n),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .head           (head),
    .empty          (empty),
    .inst_ready     (inst_ready),
    .pop            (pop),
    .inst_valid     (inst_valid),
    .inst_out       (inst_out)
  );

endmodule

`default_nettype wire

// File: source/inst_aligner.sv
`timescale 1ns/1ps
`default_nettype none

module inst_aligner
  import mem_pkg::*;
  import fetch_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         redirect_valid,
  input  pc_t          redirect_pc,
  input  fetch_entry_t head,
  input  logic         empty,
  input  logic         inst_ready,
  output logic         pop,
  output logic         inst_valid,
  output fetch_inst_t  inst_out
);

  localparam int INST_W = $bits(inst_t);

  word_off_t offset;
  word_off_t redirect_off;
  logic      accept;
  logic      last_word;

  assign redirect_off = redirect_pc[$bits(word_off_t)+1:2];

  // the head line stays put until its last word is taken, so the
  // output holds by itself while the decoder stalls.
  assign inst_valid = !empty;
  assign accept     = inst_valid && inst_ready;
  assign last_word  = &offset;
  assign pop        = accept && last_word;

  assign inst_out.pc   = pc_t'(head.addr) | pc_t'({offset, 2'b00});
  assign inst_out.inst = head.data[offset*INST_W +: INST_W];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      offset <= '0;
    end else if (redirect_valid) begin
      offset <= redirect_off;   // first line may start mid-line.
    end else if (accept) begin
      offset <= last_word ? '0 : offset + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: source/mem_pkg.sv
`default_nettype none

`include "fetch_params.svh"

package mem_pkg;

  // byte address of a line, low four bits are always zero.
  typedef logic [`ADDR_W-1:0] line_addr_t;

  // word 0 of the line sits in the low bits.
  typedef logic [`LINE_BYTES*8-1:0] line_data_t;

  // generation tag, flips on each redirect.
  typedef logic epoch_t;

  typedef struct packed {
    line_addr_t addr;
    epoch_t     epoch;
  } mem_req_t;

  typedef struct packed {
    line_data_t data;
    epoch_t     epoch;   // copied from the request.
  } mem_rsp_t;

endpackage

`default_nettype wire

// File: src.f
+incdir+source
source/mem_pkg.sv
source/fetch_pkg.sv
source/fetch_pc_gen.sv
source/fetch_buffer.sv
source/inst_aligner.sv
source/fetch_top.sv
test/fetch_assert.sv
test/fetch_tb.sv

// File: test/fetch_assert.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module fetch_assert
  import mem_pkg::*;
  import fetch_pkg::*;
(
  input logic        clk,
  input logic        rst_n,
  input logic        redirect_valid,
  input pc_t         redirect_pc,
  input logic        mem_req_valid,
  input mem_req_t    mem_req,
  input logic        mem_rsp_valid,
  input logic        inst_valid,
  input logic        inst_ready,
  input fetch_inst_t inst_out,
  input logic        full,
  input logic [31:0] inst_salt
);

  int unsigned fail_count = 0;

  pc_t        exp_pc;         // pc the decoder should accept next.
  line_addr_t exp_req_addr;   // line the restart request must ask for.
  int         pending;        // requests without a response, any epoch.
  int         stale;          // part of pending that belongs to old epochs.
  logic       in_reset_q;

  always_ff @(posedge clk) begin
    in_reset_q <= !rst_n;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      exp_pc  <= `RESET_PC;
      pending <= 0;
      stale   <= 0;
    end else begin
      pending <= pending + int'(mem_req_valid) - int'(mem_rsp_valid);
      if (redirect_valid) begin
        // responses come in order, so all that is in flight is now old.
        exp_pc       <= redirect_pc;
        exp_req_addr <= line_addr_t'(redirect_pc - (redirect_pc % `LINE_BYTES));
        stale        <= pending + int'(mem_req_valid) - int'(mem_rsp_valid);
      end else begin
        if (inst_valid && inst_ready) begin
          exp_pc <= exp_pc + 32'd4;
        end
        if (mem_rsp_valid && stale > 0) begin
          stale <= stale - 1;
        end
      end
    end
  end

  a_reset_quiet: assert property (@(posedge clk)
    (!rst_n && in_reset_q) |-> (!mem_req_valid && !inst_valid))
    else begin
      fail_count++;
      $error("request or instruction strobe active during reset");
    end

  a_pc_seq: assert property (@(posedge clk) disable iff (!rst_n)
    (inst_valid && inst_ready) |-> (inst_out.pc == exp_pc))
    else begin
      fail_count++;
      $error("ERR inst_out.pc %h expected %h", $sampled(inst_out.pc), $sampled(exp_pc));
    end

  a_inst_data: assert property (@(posedge clk) disable iff (!rst_n)
    (inst_valid && inst_ready) |-> (inst_out.inst == (exp_pc ^ inst_salt)))
    else begin
      fail_count++;
      $error("ERR inst_out.inst %h expected %h", $sampled(inst_out.inst),
             $sampled(exp_pc) ^ inst_salt);
    end

  // the restart request asks for the target line in the next cycle.
  a_redirect_req: assert property (@(posedge clk) disable iff (!rst_n)
    redirect_valid |=> (mem_req_valid && (mem_req.addr == exp_req_addr)))
    else begin
      fail_count++;
      $error("ERR mem_req.addr %h valid %h expected %h", $sampled(mem_req.addr),
             $sampled(mem_req_valid), $sampled(exp_req_addr));
    end

  // a stalled instruction must wait unchanged.
  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (inst_valid && !inst_ready && !redirect_valid) |=> (inst_valid && $stable(inst_out)))
    else begin
      fail_count++;
      $error("inst_out changed or dropped while the decoder stalled");
    end

  a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
    mem_rsp_valid |-> !full)
    else begin
      fail_count++;
      $error("response arrived while the fetch buffer was full");
    end

  a_credit: assert property (@(posedge clk) disable iff (!rst_n)
    (pending - stale) <= `FETCH_DEPTH)
    else begin
      fail_count++;
      $error("ERR outstanding %h exceeds depth %h", $sampled(pending - stale), `FETCH_DEPTH);
    end

endmodule

`default_nettype wire

// File: test/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module fetch_tb
  import mem_pkg::*;
  import fetch_pkg::*;
();

  localparam logic [31:0] inst_salt = 32'h5a3c_96e1;

  logic        clk;
  logic        rst_n;
  logic        redirect_valid;
  pc_t         redirect_pc;
  logic        mem_rsp_valid = 1'b0;
  mem_rsp_t    mem_rsp = '0;
  logic        inst_ready = 1'b0;
  logic        mem_req_valid;
  mem_req_t    mem_req;
  logic        inst_valid;
  fetch_inst_t inst_out;

  logic [31:0] lfsr = 32'h279a;
  logic [1:0]  ready_mode = 2'd0;   // 0 ready, 1 random, 2 stalled.
  mem_req_t    req_q[$];
  int          due_q[$];
  int          cycle = 0;
  int          accepted = 0;
  int          in_flight = 0;
  int          timeouts = 0;
  int          timeouts_mark = 0;
  int unsigned fails_mark = 0;
  int          tests_run = 0;

  fetch_top u_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .mem_rsp_valid  (mem_rsp_valid),
    .mem_rsp        (mem_rsp),
    .inst_ready     (inst_ready),
    .mem_req_valid  (mem_req_valid),
    .mem_req        (mem_req),
    .inst_valid     (inst_valid),
    .inst_out       (inst_out)
  );

  bind fetch_top fetch_assert u_assert (
    .clk            (clk),
    .rst_n          (rst_n),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .mem_req_valid  (mem_req_valid),
    .mem_req        (mem_req),
    .mem_rsp_valid  (mem_rsp_valid),
    .inst_valid     (inst_valid),
    .inst_ready     (inst_ready),
    .inst_out       (inst_out),
    .full           (full),
    .inst_salt      (fetch_tb.inst_salt)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // galois form of x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [7:0] take_bits(input int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[6:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return v;
  endfunction

  function automatic line_data_t line_of(input line_addr_t addr);
    line_data_t line;
    for (int w = 0; w < `WORDS_PER_LINE; w++) begin
      line[w*32 +: 32] = (addr + 32'(w * 4)) ^ inst_salt;
    end
    return line;
  endfunction

  // memory and decoder models share one process, so the lfsr draws stay in order.
  always @(posedge clk) begin
    int       due;
    mem_req_t req;
    cycle++;
    if (!rst_n) begin
      req_q.delete();
      due_q.delete();
      mem_rsp_valid <= 1'b0;
      in_flight     <= 0;
    end else begin
      if (mem_req_valid) begin
        due = cycle + int'(take_bits(3));
        if (due_q.size() > 0 && due <= due_q[$]) begin
          due = due_q[$] + 1;   // keep one response per cycle, in order.
        end
        req_q.push_back(mem_req);
        due_q.push_back(due);
      end
      if (due_q.size() > 0 && due_q[0] <= cycle) begin
        req = req_q.pop_front();
        due = due_q.pop_front();
        mem_rsp_valid <= 1'b1;
        mem_rsp.data  <= line_of(req.addr);
        mem_rsp.epoch <= req.epoch;
      end else begin
        mem_rsp_valid <= 1'b0;
      end
      in_flight <= req_q.size();
    end
    case (ready_mode)
      2'd0: inst_ready <= 1'b1;
      2'd1: inst_ready <= (take_bits(2) != 8'd0);
      default: inst_ready <= 1'b0;
    endcase
    if (inst_valid && inst_ready) begin
      accepted <= accepted + 1;
    end
  end

  task automatic wait_accepts(input int n, input string what);
    int start;
    int waited;
    start  = accepted;
    waited = 0;
    while (accepted - start < n && waited < n * 20 + 200) begin
      @(posedge clk);
      waited++;
    end
    if (accepted - start < n) begin
      $display("timeout: decoder took fewer than %0d instructions in %s", n, what);
      timeouts++;
    end
  endtask

  task automatic wait_in_flight(input int n, input string what);
    int waited;
    waited = 0;
    while (in_flight < n && waited < 200) begin
      @(posedge clk);
      waited++;
    end
    if (in_flight < n) begin
      $display("timeout: fewer than %0d lines in flight in %s", n, what);
      timeouts++;
    end
  endtask

  task automatic redirect_to(input pc_t target, input bit last);
    @(posedge clk);
    redirect_valid <= 1'b1;
    redirect_pc    <= target;
    if (last) begin
      @(posedge clk);
      redirect_valid <= 1'b0;
    end
  endtask

  task automatic report_test(input string name);
    int unsigned fails;
    fails = u_dut.u_assert.fail_count - fails_mark;
    tests_run++;
    $display("test %0d %s: %0d assertion failures, %0d timeouts", tests_run, name, fails,
             timeouts - timeouts_mark);
    fails_mark    = u_dut.u_assert.fail_count;
    timeouts_mark = timeouts;
  endtask

  initial begin
    rst_n          = 1'b0;
    redirect_valid = 1'b0;
    redirect_pc    = '0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    wait_accepts(40, "reset and stream");
    report_test("reset and stream");

    @(posedge clk);
    ready_mode <= 2'd1;
    wait_accepts(120, "random latency");
    report_test("random latency");

    // two long stalls, each long enough to fill the buffer.
    for (int i = 0; i < 2; i++) begin
      @(posedge clk);
      ready_mode <= 2'd2;
      repeat (60) @(posedge clk);
      ready_mode <= 2'd0;
      wait_accepts(30, "back-pressure");
    end
    report_test("back-pressure");

    @(posedge clk);
    ready_mode <= 2'd1;
    wait_accepts(5, "redirect in flight");
    wait_in_flight(2, "redirect in flight");
    redirect_to(32'h8000_2008, 1'b1);
    wait_accepts(30, "redirect in flight");
    report_test("redirect in flight");

    wait_in_flight(2, "back-to-back redirects");
    redirect_to(32'h8001_0004, 1'b0);
    redirect_to(32'h8002_000c, 1'b0);
    redirect_to(32'h8000_3008, 1'b1);
    wait_accepts(30, "back-to-back redirects");
    report_test("back-to-back redirects");

    repeat (20) @(posedge clk);
    $display("summary: %0d tests, %0d assertion failures, %0d timeouts", tests_run,
             u_dut.u_assert.fail_count, timeouts);
    if (u_dut.u_assert.fail_count == 0 && timeouts == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
